// File: Makefile
# Verilator build and run of the camera edge detection testbench

VERILATOR ?= verilator
TOP       ?= cam_edge_tb
FILELIST  ?= cam_edge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cam_edge.f
hdl/cam_edge_pkg.sv
hdl/sobel_window_if.sv
hdl/pixel_capture.sv
hdl/frame_buffer.sv
hdl/sobel_window_feeder.sv
hdl/sobel_lane.sv
hdl/edge_writer.sv
hdl/vga_scan.sv
hdl/cam_edge_top.sv
tb/cam_edge_tb.sv

// File: hdl/cam_edge_pkg.sv
// Frame and raster sizes, lane count and edge threshold
// Address, pixel and gray types, mode state enum
`default_nettype none

package cam_edge_pkg;

    // Image size
    localparam int FRAME_W      = 16;
    localparam int FRAME_H      = 12;
    localparam int FRAME_PIXELS = FRAME_W * FRAME_H;

    // Sobel lanes per batch, FRAME_W is a multiple of this
    localparam int LANES = 4;

    // Horizontal raster in clocks
    localparam int H_ACTIVE = 16;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BACK   = 2;

    // Vertical raster in lines
    localparam int V_ACTIVE = 12;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 1;

    // Minimum |gx| + |gy| for an edge
    localparam int EDGE_THRESHOLD = 64;

    typedef logic [7:0]  pix_addr_t;
    typedef logic [11:0] rgb444_t;
    // r + 2g + b, max 60
    typedef logic [5:0]  gray_t;

    typedef enum logic [1:0] {
        S_SHOW_LIVE,
        S_WAIT_FRAME,
        S_EDGE_RUN,
        S_SHOW_EDGE
    } cam_mode_e;

endpackage

`default_nettype wire

// File: hdl/cam_edge_top.sv
// Camera to VGA edge detection top level
// Mode FSM, frame buffer port multiplexing and all instances
`default_nettype none

module cam_edge_top (
    input  logic       clk_25_vga,
    input  logic       reset_global,
    input  logic       edge_mode,
    input  logic       cam_vsync,
    input  logic       cam_href,
    input  logic [7:0] cam_data,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic       vga_blank_n,
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b,
    output logic       edge_busy,
    output logic       frame_done
);
    cam_edge_pkg::cam_mode_e        state;
    cam_edge_pkg::cam_mode_e        state_next;
    logic                           feed_start;
    logic                           disp_fb2_q;

    logic                           cap_wr_en;
    cam_edge_pkg::pix_addr_t        cap_wr_addr;
    cam_edge_pkg::rgb444_t          cap_wr_data;

    logic                           fb1_wr_en;
    cam_edge_pkg::pix_addr_t        fb1_rd_addr;
    cam_edge_pkg::rgb444_t          fb1_rd_data;
    cam_edge_pkg::rgb444_t          fb2_rd_data;
    cam_edge_pkg::rgb444_t          disp_data;

    cam_edge_pkg::pix_addr_t        feed_rd_addr;
    cam_edge_pkg::pix_addr_t        vga_rd_addr;
    logic [cam_edge_pkg::LANES-1:0] edge_bits;
    logic                           ew_wr_en;
    cam_edge_pkg::pix_addr_t        ew_wr_addr;
    cam_edge_pkg::rgb444_t          ew_wr_data;
    logic                           pass_done;

    sobel_window_if win_if ();

    always_comb begin
        state_next = state;
        if (!edge_mode) begin
            state_next = cam_edge_pkg::S_SHOW_LIVE;
        end else begin
            case (state)
                cam_edge_pkg::S_SHOW_LIVE:  state_next = cam_edge_pkg::S_WAIT_FRAME;
                cam_edge_pkg::S_WAIT_FRAME: if (frame_done) state_next = cam_edge_pkg::S_EDGE_RUN;
                cam_edge_pkg::S_EDGE_RUN:   if (pass_done) state_next = cam_edge_pkg::S_SHOW_EDGE;
                cam_edge_pkg::S_SHOW_EDGE:  if (frame_done) state_next = cam_edge_pkg::S_WAIT_FRAME;
                default:                    state_next = cam_edge_pkg::S_SHOW_LIVE;
            endcase
        end
    end

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            state      <= cam_edge_pkg::S_SHOW_LIVE;
            feed_start <= 1'b0;
            disp_fb2_q <= 1'b0;
        end else begin
            state      <= state_next;
            feed_start <= state_next == cam_edge_pkg::S_EDGE_RUN
                          && state != cam_edge_pkg::S_EDGE_RUN;
            // Select follows the RAM read latency
            disp_fb2_q <= state == cam_edge_pkg::S_EDGE_RUN
                          || state == cam_edge_pkg::S_SHOW_EDGE;
        end
    end

    assign edge_busy = state == cam_edge_pkg::S_EDGE_RUN;

    // Feeder owns buffer 1 during an edge pass, capture is held off
    assign fb1_wr_en   = cap_wr_en && state != cam_edge_pkg::S_EDGE_RUN;
    assign fb1_rd_addr = (state == cam_edge_pkg::S_EDGE_RUN) ? feed_rd_addr : vga_rd_addr;
    assign disp_data   = disp_fb2_q ? fb2_rd_data : fb1_rd_data;

    pixel_capture u_capture (
        .clk_25_vga   (clk_25_vga),
        .reset_global (reset_global),
        .cam_vsync    (cam_vsync),
        .cam_href     (cam_href),
        .cam_data     (cam_data),
        .wr_en        (cap_wr_en),
        .wr_addr      (cap_wr_addr),
        .wr_data      (cap_wr_data),
        .frame_done   (frame_done)
    );

    frame_buffer u_fb1 (
        .clk_25_vga (clk_25_vga),
        .wr_en      (fb1_wr_en),
        .wr_addr    (cap_wr_addr),
        .wr_data    (cap_wr_data),
        .rd_addr    (fb1_rd_addr),
        .rd_data    (fb1_rd_data)
    );

    frame_buffer u_fb2 (
        .clk_25_vga (clk_25_vga),
        .wr_en      (ew_wr_en),
        .wr_addr    (ew_wr_addr),
        .wr_data    (ew_wr_data),
        .rd_addr    (vga_rd_addr),
        .rd_data    (fb2_rd_data)
    );

    sobel_window_feeder u_feeder (
        .clk_25_vga   (clk_25_vga),
        .reset_global (reset_global),
        .start        (feed_start),
        .rd_addr      (feed_rd_addr),
        .rd_data      (fb1_rd_data),
        .win          (win_if)
    );

    for (genvar i = 0; i < cam_edge_pkg::LANES; i++) begin : g_lane
        sobel_lane #(
            .LANE_INDEX (i)
        ) u_lane (
            .clk_25_vga   (clk_25_vga),
            .reset_global (reset_global),
            .win          (win_if),
            .edge_bit     (edge_bits[i])
        );
    end

    edge_writer u_writer (
        .clk_25_vga   (clk_25_vga),
        .reset_global (reset_global),
        .win          (win_if),
        .edge_bits    (edge_bits),
        .wr_en        (ew_wr_en),
        .wr_addr      (ew_wr_addr),
        .wr_data      (ew_wr_data),
        .pass_done    (pass_done)
    );

    vga_scan u_vga (
        .clk_25_vga   (clk_25_vga),
        .reset_global (reset_global),
        .rd_data      (disp_data),
        .rd_addr      (vga_rd_addr),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_blank_n  (vga_blank_n),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b)
    );
endmodule

`default_nettype wire

// File: hdl/edge_writer.sv
// Serializes the lane edge bits into frame buffer 2, pass-done pulse
`default_nettype none

module edge_writer (
    input  logic                           clk_25_vga,
    input  logic                           reset_global,
    sobel_window_if.writer                 win,
    input  logic [cam_edge_pkg::LANES-1:0] edge_bits,
    output logic                           wr_en,
    output cam_edge_pkg::pix_addr_t        wr_addr,
    output cam_edge_pkg::rgb444_t          wr_data,
    output logic                           pass_done
);
    logic                                   valid_q;
    logic                                   busy;
    logic [$clog2(cam_edge_pkg::LANES)-1:0] k;
    logic [cam_edge_pkg::LANES-1:0]         bits_q;
    cam_edge_pkg::pix_addr_t                base_q;
    logic                                   last_q;

    // Lane k written k+1 cycles after the lane outputs
    assign wr_en   = busy;
    assign wr_addr = base_q + cam_edge_pkg::pix_addr_t'(k);
    assign wr_data = bits_q[k] ? 12'hfff : 12'h000;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            valid_q   <= 1'b0;
            busy      <= 1'b0;
            k         <= '0;
            pass_done <= 1'b0;
        end else begin
            valid_q   <= win.win_valid;
            pass_done <= 1'b0;
            if (valid_q) begin
                busy <= 1'b1;
                k    <= '0;
            end else if (busy) begin
                k <= k + 1'b1;
                if (k == $bits(k)'(cam_edge_pkg::LANES - 1)) begin
                    busy      <= 1'b0;
                    pass_done <= last_q;
                end
            end
        end
    end

    // Batch position still stable one cycle after win_valid
    always_ff @(posedge clk_25_vga) begin
        if (valid_q) begin
            bits_q <= edge_bits;
            base_q <= cam_edge_pkg::pix_addr_t'(win.row_y * cam_edge_pkg::FRAME_W + win.base_x);
            last_q <= win.last;
        end
    end
endmodule

`default_nettype wire

// File: hdl/frame_buffer.sv
// Dual-port pixel RAM, one write port and one registered read port
`default_nettype none

module frame_buffer (
    input  logic                    clk_25_vga,
    input  logic                    wr_en,
    input  cam_edge_pkg::pix_addr_t wr_addr,
    input  cam_edge_pkg::rgb444_t   wr_data,
    input  cam_edge_pkg::pix_addr_t rd_addr,
    output cam_edge_pkg::rgb444_t   rd_data
);
    cam_edge_pkg::rgb444_t mem [cam_edge_pkg::FRAME_PIXELS];

    always_ff @(posedge clk_25_vga) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end
endmodule

`default_nettype wire

// File: hdl/pixel_capture.sv
// Camera byte pair to RGB444 pixel capture
// Frame-relative write address and frame-done pulse
`default_nettype none

module pixel_capture (
    input  logic                    clk_25_vga,
    input  logic                    reset_global,
    input  logic                    cam_vsync,
    input  logic                    cam_href,
    input  logic [7:0]              cam_data,
    output logic                    wr_en,
    output cam_edge_pkg::pix_addr_t wr_addr,
    output cam_edge_pkg::rgb444_t   wr_data,
    output logic                    frame_done
);
    logic                    vsync_q;
    logic                    href_q;
    logic                    byte_phase;
    logic [3:0]              red_q;
    cam_edge_pkg::pix_addr_t addr;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            vsync_q    <= 1'b0;
            href_q     <= 1'b0;
            byte_phase <= 1'b0;
            addr       <= '0;
            wr_en      <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            vsync_q    <= cam_vsync;
            href_q     <= cam_href;
            wr_en      <= 1'b0;
            // Row end after the last pixel of the frame
            frame_done <= href_q && !cam_href
                          && addr == cam_edge_pkg::pix_addr_t'(cam_edge_pkg::FRAME_PIXELS);
            if (cam_vsync && !vsync_q) begin
                addr       <= '0;
                byte_phase <= 1'b0;
            end else if (cam_href) begin
                byte_phase <= ~byte_phase;
                if (byte_phase) begin
                    wr_en <= 1'b1;
                    addr  <= addr + 8'd1;
                end
            end else begin
                byte_phase <= 1'b0;
            end
        end
    end

    // First byte carries red, second green and blue
    always_ff @(posedge clk_25_vga) begin
        if (cam_href && !byte_phase) begin
            red_q <= cam_data[3:0];
        end
        wr_addr <= addr;
        wr_data <= {red_q, cam_data};
    end
endmodule

`default_nettype wire

// File: hdl/sobel_lane.sv
// One Sobel lane, gradient magnitude threshold with border suppression
`default_nettype none

module sobel_lane #(
    parameter int LANE_INDEX = 0
) (
    input  logic         clk_25_vga,
    input  logic         reset_global,
    sobel_window_if.lane win,
    output logic         edge_bit
);
    logic signed [9:0] p [3][3];
    logic signed [9:0] gx;
    logic signed [9:0] gy;
    logic [9:0]        mag;
    logic [3:0]        col_x;
    logic              border;

    always_comb begin
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                p[r][c] = $signed({4'b0, win.gray[r][LANE_INDEX + c]});
            end
        end
        gx  = (p[0][2] + (p[1][2] <<< 1) + p[2][2]) - (p[0][0] + (p[1][0] <<< 1) + p[2][0]);
        gy  = (p[2][0] + (p[2][1] <<< 1) + p[2][2]) - (p[0][0] + (p[0][1] <<< 1) + p[0][2]);
        mag = (gx[9] ? 10'(-gx) : 10'(gx)) + (gy[9] ? 10'(-gy) : 10'(gy));
    end

    // No full window on the outer ring of the frame
    assign col_x  = win.base_x + 4'(LANE_INDEX);
    assign border = col_x == 4'd0 || col_x == 4'(cam_edge_pkg::FRAME_W - 1)
                    || win.row_y == 4'd0 || win.row_y == 4'(cam_edge_pkg::FRAME_H - 1);

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            edge_bit <= 1'b0;
        end else if (win.win_valid) begin
            edge_bit <= !border && mag >= 10'(cam_edge_pkg::EDGE_THRESHOLD);
        end
    end
endmodule

`default_nettype wire

// File: hdl/sobel_window_feeder.sv
// Frame buffer walk in four-column groups with gray conversion
// Fills the 3x6 window and strobes one batch per group
`default_nettype none

module sobel_window_feeder (
    input  logic                    clk_25_vga,
    input  logic                    reset_global,
    input  logic                    start,
    output cam_edge_pkg::pix_addr_t rd_addr,
    input  cam_edge_pkg::rgb444_t   rd_data,
    sobel_window_if.feeder          win
);
    logic                                           active;
    logic [4:0]                                     cnt;
    logic [1:0]                                     rd_r;
    logic [$clog2(cam_edge_pkg::LANES+2)-1:0]       rd_c;
    logic [3:0]                                     cur_row;
    logic [3:0]                                     cur_base;
    logic [5:0]                                     cell_y;
    logic [5:0]                                     cell_x;
    logic                                           cell_ok;
    logic                                           batch_end;
    logic                                           st_vld;
    logic                                           st_ok;
    logic [1:0]                                     st_r;
    logic [$clog2(cam_edge_pkg::LANES+2)-1:0]       st_c;

    function automatic cam_edge_pkg::gray_t to_gray(input cam_edge_pkg::rgb444_t px);
        return {2'b0, px[11:8]} + {1'b0, px[7:4], 1'b0} + {2'b0, px[3:0]};
    endfunction

    // Cell coordinates carried with a +1 offset so that -1 stays unsigned
    assign cell_y  = {2'b0, cur_row} + 6'(rd_r);
    assign cell_x  = {2'b0, cur_base} + 6'(rd_c);
    assign cell_ok = cell_y != 6'd0 && cell_y <= 6'(cam_edge_pkg::FRAME_H)
                     && cell_x != 6'd0 && cell_x <= 6'(cam_edge_pkg::FRAME_W);
    assign rd_addr = cam_edge_pkg::pix_addr_t'((cell_y - 6'd1) * cam_edge_pkg::FRAME_W
                                               + (cell_x - 6'd1));

    // 18 read cycles, the last data returns on the 19th
    assign batch_end = active && cnt == 5'(3 * (cam_edge_pkg::LANES + 2));

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            active        <= 1'b0;
            cnt           <= '0;
            rd_r          <= '0;
            rd_c          <= '0;
            cur_row       <= '0;
            cur_base      <= '0;
            st_vld        <= 1'b0;
            win.win_valid <= 1'b0;
        end else begin
            win.win_valid <= batch_end;
            st_vld        <= active && !batch_end;
            if (start) begin
                active   <= 1'b1;
                cnt      <= '0;
                rd_r     <= '0;
                rd_c     <= '0;
                cur_row  <= '0;
                cur_base <= '0;
            end else if (batch_end) begin
                cnt  <= '0;
                rd_r <= '0;
                rd_c <= '0;
                if (cur_base == 4'(cam_edge_pkg::FRAME_W - cam_edge_pkg::LANES)) begin
                    cur_base <= '0;
                    if (cur_row == 4'(cam_edge_pkg::FRAME_H - 1)) begin
                        active <= 1'b0;
                    end else begin
                        cur_row <= cur_row + 4'd1;
                    end
                end else begin
                    cur_base <= cur_base + 4'(cam_edge_pkg::LANES);
                end
            end else if (active) begin
                cnt <= cnt + 5'd1;
                if (rd_c == $bits(rd_c)'(cam_edge_pkg::LANES + 1)) begin
                    rd_c <= '0;
                    rd_r <= rd_r + 2'd1;
                end else begin
                    rd_c <= rd_c + 1'b1;
                end
            end
        end
    end

    // Cells outside the frame read as zero
    always_ff @(posedge clk_25_vga) begin
        st_r  <= rd_r;
        st_c  <= rd_c;
        st_ok <= cell_ok;
        if (st_vld) begin
            win.gray[st_r][st_c] <= st_ok ? to_gray(rd_data) : '0;
        end
        if (batch_end) begin
            win.row_y  <= cur_row;
            win.base_x <= cur_base;
            win.last   <= cur_row == 4'(cam_edge_pkg::FRAME_H - 1)
                          && cur_base == 4'(cam_edge_pkg::FRAME_W - cam_edge_pkg::LANES);
        end
    end
endmodule

`default_nettype wire

// File: hdl/sobel_window_if.sv
// Window batch from the feeder to the Sobel lanes and the edge writer
`default_nettype none

interface sobel_window_if;
    logic       win_valid;
    logic [3:0] row_y;
    logic [3:0] base_x;
    logic       last;
    // Rows row_y-1..row_y+1, columns base_x-1..base_x+LANES
    cam_edge_pkg::gray_t [2:0][cam_edge_pkg::LANES+1:0] gray;

    modport feeder (output win_valid, row_y, base_x, last, gray);
    modport lane   (input win_valid, row_y, base_x, last, gray);
    modport writer (input win_valid, row_y, base_x, last);
endinterface

`default_nettype wire

// File: hdl/vga_scan.sv
// Raster counters, active-low syncs, read address and RGB output
`default_nettype none

module vga_scan (
    input  logic                    clk_25_vga,
    input  logic                    reset_global,
    input  cam_edge_pkg::rgb444_t   rd_data,
    output cam_edge_pkg::pix_addr_t rd_addr,
    output logic                    vga_hsync,
    output logic                    vga_vsync,
    output logic                    vga_blank_n,
    output logic [7:0]              vga_r,
    output logic [7:0]              vga_g,
    output logic [7:0]              vga_b
);
    logic [4:0] h_cnt;
    logic [4:0] v_cnt;
    logic       active;
    logic       hsync_c;
    logic       vsync_c;
    logic       active_q;
    logic       hsync_q;
    logic       vsync_q;

    assign active  = h_cnt < 5'(cam_edge_pkg::H_ACTIVE) && v_cnt < 5'(cam_edge_pkg::V_ACTIVE);
    assign hsync_c = h_cnt >= 5'(cam_edge_pkg::H_ACTIVE + cam_edge_pkg::H_FRONT)
                     && h_cnt < 5'(cam_edge_pkg::H_ACTIVE + cam_edge_pkg::H_FRONT
                                   + cam_edge_pkg::H_SYNC);
    assign vsync_c = v_cnt >= 5'(cam_edge_pkg::V_ACTIVE + cam_edge_pkg::V_FRONT)
                     && v_cnt < 5'(cam_edge_pkg::V_ACTIVE + cam_edge_pkg::V_FRONT
                                   + cam_edge_pkg::V_SYNC);
    assign rd_addr = active ? cam_edge_pkg::pix_addr_t'(v_cnt * cam_edge_pkg::FRAME_W + h_cnt)
                            : '0;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            active_q    <= 1'b0;
            hsync_q     <= 1'b0;
            vsync_q     <= 1'b0;
            vga_hsync   <= 1'b1;
            vga_vsync   <= 1'b1;
            vga_blank_n <= 1'b0;
            vga_r       <= '0;
            vga_g       <= '0;
            vga_b       <= '0;
        end else begin
            if (h_cnt == 5'(cam_edge_pkg::H_ACTIVE + cam_edge_pkg::H_FRONT
                            + cam_edge_pkg::H_SYNC + cam_edge_pkg::H_BACK - 1)) begin
                h_cnt <= '0;
                if (v_cnt == 5'(cam_edge_pkg::V_ACTIVE + cam_edge_pkg::V_FRONT
                                + cam_edge_pkg::V_SYNC + cam_edge_pkg::V_BACK - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 5'd1;
                end
            end else begin
                h_cnt <= h_cnt + 5'd1;
            end
            // First stage matches the RAM read latency
            active_q    <= active;
            hsync_q     <= hsync_c;
            vsync_q     <= vsync_c;
            vga_hsync   <= !hsync_q;
            vga_vsync   <= !vsync_q;
            vga_blank_n <= active_q;
            vga_r       <= active_q ? {rd_data[11:8], rd_data[11:8]} : 8'h00;
            vga_g       <= active_q ? {rd_data[7:4], rd_data[7:4]} : 8'h00;
            vga_b       <= active_q ? {rd_data[3:0], rd_data[3:0]} : 8'h00;
        end
    end
endmodule

`default_nettype wire

// File: tb/cam_edge_stim.txt
// One row of 16 pixels per line, each entry is {edge bit, rgb444} in hex
// Lines 1-12 hold the live frame (edge bits unused), lines 13-24 the edge frame
0000 0011 0022 0033 0044 0055 0066 0077 0088 0099 00aa 00bb 00cc 00dd 00ee 00ff
0101 0112 0123 0134 0145 0156 0167 0178 0189 019a 01ab 01bc 01cd 01de 01ef 01f0
0202 0213 0224 0235 0246 0257 0268 0279 028a 029b 02ac 02bd 02ce 02df 02e0 02f1
0303 0314 0325 0336 0347 0358 0369 037a 038b 039c 03ad 03be 03cf 03d0 03e1 03f2
0404 0415 0426 0437 0448 0459 046a 047b 048c 049d 04ae 04bf 04c0 04d1 04e2 04f3
0505 0516 0527 0538 0549 055a 056b 057c 058d 059e 05af 05b0 05c1 05d2 05e3 05f4
0606 0617 0628 0639 064a 065b 066c 067d 068e 069f 06a0 06b1 06c2 06d3 06e4 06f5
0707 0718 0729 073a 074b 075c 076d 077e 078f 0790 07a1 07b2 07c3 07d4 07e5 07f6
0808 0819 082a 083b 084c 085d 086e 087f 0880 0891 08a2 08b3 08c4 08d5 08e6 08f7
0909 091a 092b 093c 094d 095e 096f 0970 0981 0992 09a3 09b4 09c5 09d6 09e7 09f8
0a0a 0a1b 0a2c 0a3d 0a4e 0a5f 0a60 0a71 0a82 0a93 0aa4 0ab5 0ac6 0ad7 0ae8 0af9
0b0b 0b1c 0b2d 0b3e 0b4f 0b50 0b61 0b72 0b83 0b94 0ba5 0bb6 0bc7 0bd8 0be9 0bfa
0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123
0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123
0123 0123 0123 1123 1123 1123 1123 1123 1123 1123 1123 1123 1123 0123 0123 0123
0123 0123 0123 1123 1edc 1edc 1edc 1edc 1edc 1edc 1edc 1edc 1123 0123 0123 0123
0123 0123 0123 1123 1edc 0edc 0edc 0edc 0edc 0edc 0edc 1edc 1123 0123 0123 0123
0123 0123 0123 1123 1edc 0edc 0edc 0edc 0edc 0edc 0edc 1edc 1123 0123 0123 0123
0123 0123 0123 1123 1edc 0edc 0edc 0edc 0edc 0edc 0edc 1edc 1123 0123 0123 0123
0123 0123 0123 1123 1edc 0edc 0edc 0edc 0edc 0edc 0edc 1edc 1123 0123 0123 0123
0123 0123 0123 1123 1edc 1edc 1edc 1edc 1edc 1edc 1edc 1edc 1123 0123 0123 0123
0123 0123 0123 1123 1123 1123 1123 1123 1123 1123 1123 1123 1123 0123 0123 0123
0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123
0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123 0123

// File: tb/cam_edge_tb.sv
// Self-checking testbench for the camera to VGA edge detection top level
// Camera frames and expected edge bits come from the stim file
`default_nettype none

module cam_edge_tb;
    logic       clk_25_vga;
    logic       reset_global;
    logic       edge_mode;
    logic       cam_vsync;
    logic       cam_href;
    logic [7:0] cam_data;
    logic       vga_hsync;
    logic       vga_vsync;
    logic       vga_blank_n;
    logic [7:0] vga_r;
    logic [7:0] vga_g;
    logic [7:0] vga_b;
    logic       edge_busy;
    logic       frame_done;

    // Two frames of {edge bit, rgb444}, live frame first
    logic [12:0] stim_mem [2 * cam_edge_pkg::FRAME_PIXELS];
    logic [31:0] lfsr_state;
    int          errors = 0;
    int          checks = 0;
    int          done_pulses = 0;
    int          busy_rises = 0;
    int          busy_falls = 0;
    logic        busy_prev = 1'b0;

    cam_edge_top dut_i (
        .clk_25_vga   (clk_25_vga),
        .reset_global (reset_global),
        .edge_mode    (edge_mode),
        .cam_vsync    (cam_vsync),
        .cam_href     (cam_href),
        .cam_data     (cam_data),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_blank_n  (vga_blank_n),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b),
        .edge_busy    (edge_busy),
        .frame_done   (frame_done)
    );

    always #5 clk_25_vga = ~clk_25_vga;

    // Pulse and edge counters, sampled mid-cycle
    always @(negedge clk_25_vga) begin
        if (frame_done === 1'b1) begin
            done_pulses++;
        end
        if (edge_busy === 1'b1 && busy_prev === 1'b0) begin
            busy_rises++;
        end
        if (edge_busy === 1'b0 && busy_prev === 1'b1) begin
            busy_falls++;
        end
        busy_prev = edge_busy;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    function automatic logic [23:0] expand_rgb(input logic [11:0] px);
        return {px[11:8], px[11:8], px[7:4], px[7:4], px[3:0], px[3:0]};
    endfunction

    // Gray r+2g+b of a stim pixel, zero outside the frame
    function automatic int gray_of(input int frame_sel, input int x, input int y);
        logic [11:0] px;
        if (x < 0 || x >= cam_edge_pkg::FRAME_W || y < 0 || y >= cam_edge_pkg::FRAME_H) begin
            return 0;
        end
        px = stim_mem[frame_sel * cam_edge_pkg::FRAME_PIXELS
                      + y * cam_edge_pkg::FRAME_W + x][11:0];
        return int'(px[11:8]) + 2 * int'(px[7:4]) + int'(px[3:0]);
    endfunction

    function automatic logic sobel_bit(input int frame_sel, input int x, input int y);
        int gx;
        int gy;
        if (x == 0 || x == cam_edge_pkg::FRAME_W - 1
            || y == 0 || y == cam_edge_pkg::FRAME_H - 1) begin
            return 1'b0;
        end
        gx = gray_of(frame_sel, x + 1, y - 1) + 2 * gray_of(frame_sel, x + 1, y)
             + gray_of(frame_sel, x + 1, y + 1) - gray_of(frame_sel, x - 1, y - 1)
             - 2 * gray_of(frame_sel, x - 1, y) - gray_of(frame_sel, x - 1, y + 1);
        gy = gray_of(frame_sel, x - 1, y + 1) + 2 * gray_of(frame_sel, x, y + 1)
             + gray_of(frame_sel, x + 1, y + 1) - gray_of(frame_sel, x - 1, y - 1)
             - 2 * gray_of(frame_sel, x, y - 1) - gray_of(frame_sel, x + 1, y - 1);
        if (gx < 0) gx = -gx;
        if (gy < 0) gy = -gy;
        return (gx + gy) >= cam_edge_pkg::EDGE_THRESHOLD;
    endfunction

    // Vsync pulse, then one href burst of byte pairs per row
    task automatic drive_frame(input int frame_sel);
        logic [11:0] px;
        int          gap;
        int          base;
        base = frame_sel * cam_edge_pkg::FRAME_PIXELS;
        cam_vsync = 1'b1;
        repeat (3) @(negedge clk_25_vga);
        cam_vsync = 1'b0;
        repeat (4) @(negedge clk_25_vga);
        for (int y = 0; y < cam_edge_pkg::FRAME_H; y++) begin
            for (int x = 0; x < cam_edge_pkg::FRAME_W; x++) begin
                px = stim_mem[base + y * cam_edge_pkg::FRAME_W + x][11:0];
                cam_href = 1'b1;
                cam_data = {4'b0, px[11:8]};
                @(negedge clk_25_vga);
                cam_data = px[7:0];
                @(negedge clk_25_vga);
            end
            cam_href = 1'b0;
            cam_data = 8'h00;
            random_bits(2, gap);
            repeat (gap + 2) @(negedge clk_25_vga);
        end
        repeat (4) @(negedge clk_25_vga);
    endtask

    // One displayed frame from the fall of vga_vsync, blanked RGB must be zero
    task automatic check_vga_frame(input int frame_sel, input logic edge_view);
        logic        prev;
        logic        found;
        logic        hs_prev;
        logic [11:0] px;
        int          cycles;
        int          n;
        int          hs_falls;
        prev = vga_vsync;
        found = 1'b0;
        cycles = 0;
        while (!found && cycles < 1000) begin
            @(negedge clk_25_vga);
            found = prev === 1'b1 && vga_vsync === 1'b0;
            prev = vga_vsync;
            cycles++;
        end
        if (!found) begin
            errors++;
            $display("Timeout: vga_vsync did not fall within 1000 cycles");
            return;
        end
        n = 0;
        cycles = 0;
        hs_falls = 0;
        hs_prev = vga_hsync;
        while (n < cam_edge_pkg::FRAME_PIXELS && cycles < 1000) begin
            @(negedge clk_25_vga);
            cycles++;
            if (hs_prev === 1'b1 && vga_hsync === 1'b0) begin
                hs_falls++;
            end
            hs_prev = vga_hsync;
            if (vga_blank_n === 1'b1) begin
                if (edge_view) begin
                    px = sobel_bit(frame_sel, n % cam_edge_pkg::FRAME_W,
                                   n / cam_edge_pkg::FRAME_W) ? 12'hfff : 12'h000;
                end else begin
                    px = stim_mem[frame_sel * cam_edge_pkg::FRAME_PIXELS + n][11:0];
                end
                check_value("vga_rgb", 32'({vga_r, vga_g, vga_b}), 32'(expand_rgb(px)));
                n++;
            end else begin
                check_value("vga_rgb_blanked", 32'({vga_r, vga_g, vga_b}), 32'h0);
            end
        end
        if (n < cam_edge_pkg::FRAME_PIXELS) begin
            errors++;
            $display("Timeout: only %0d active VGA pixels seen after vsync", n);
        end else begin
            // Lines from the vsync fall up to the last active line
            check_value("vga_hsync_falls", 32'(hs_falls),
                        32'(cam_edge_pkg::V_SYNC + cam_edge_pkg::V_BACK
                            + cam_edge_pkg::V_ACTIVE - 1));
        end
    endtask

    task automatic wait_busy_fall();
        int cycles;
        cycles = 0;
        while (busy_falls == 0 && cycles < 10000) begin
            @(negedge clk_25_vga);
            cycles++;
        end
        if (busy_falls == 0) begin
            errors++;
            $display("Timeout: edge_busy did not fall after the edge frame");
        end
    endtask

    initial begin
        clk_25_vga   = 1'b0;
        reset_global = 1'b1;
        edge_mode    = 1'b0;
        cam_vsync    = 1'b0;
        cam_href     = 1'b0;
        cam_data     = 8'h00;
        lfsr_state   = 32'hf716_9e2a;
        $readmemh("tb/cam_edge_stim.txt", stim_mem);
        repeat (10) @(negedge clk_25_vga);

        check_value("vga_blank_n", 32'(vga_blank_n), 32'h0);
        check_value("edge_busy", 32'(edge_busy), 32'h0);
        check_value("frame_done", 32'(frame_done), 32'h0);
        check_value("vga_hsync", 32'(vga_hsync), 32'h1);
        check_value("vga_vsync", 32'(vga_vsync), 32'h1);
        reset_global = 1'b0;

        // Live frame straight from buffer 1
        drive_frame(0);
        check_value("frame_done_pulses", 32'(done_pulses), 32'd1);
        check_vga_frame(0, 1'b0);

        // Stim edge bits against the Sobel rule
        for (int y = 0; y < cam_edge_pkg::FRAME_H; y++) begin
            for (int x = 0; x < cam_edge_pkg::FRAME_W; x++) begin
                check_value("stim_edge_bit",
                            32'(stim_mem[cam_edge_pkg::FRAME_PIXELS
                                         + y * cam_edge_pkg::FRAME_W + x][12]),
                            32'(sobel_bit(1, x, y)));
            end
        end

        // Edge pass on the second frame
        edge_mode = 1'b1;
        repeat (2) @(negedge clk_25_vga);
        drive_frame(1);
        wait_busy_fall();
        check_value("frame_done_pulses", 32'(done_pulses), 32'd2);
        check_value("edge_busy_rises", 32'(busy_rises), 32'd1);
        check_vga_frame(1, 1'b1);

        // Live image comes back from buffer 1
        edge_mode = 1'b0;
        check_vga_frame(1, 1'b0);
        check_value("edge_busy", 32'(edge_busy), 32'h0);
        check_value("frame_done_pulses", 32'(done_pulses), 32'd2);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end
endmodule

`default_nettype wire
